/* rtl/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// number of 32-bit words, also the valid address range
`define MEM_DEPTH_WORDS 256

// cycles from read-address accept to rvalid, at least 1
`define MEM_READ_DELAY 2

// word index width derived from the depth
`define MEM_INDEX_W $clog2(`MEM_DEPTH_WORDS)

`endif

/* rtl/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // response codes as seen on the bus
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } mem_resp_e;

endpackage

`default_nettype wire

/* rtl/mem_ctrl_pkg.sv */
`default_nettype none

package mem_ctrl_pkg;

    typedef enum logic [1:0] {
        rd_idle,
        rd_wait,
        rd_resp
    } rd_state_e;

    typedef enum logic [1:0] {
        wr_idle,
        wr_addr_held,
        wr_resp
    } wr_state_e;

endpackage

`default_nettype wire

/* rtl/mem_ctrl.sv */
`default_nettype none

`include "mem_config.svh"

module mem_ctrl
    import mem_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic imem_arvalid,
    output logic imem_arready,
    output logic imem_rvalid,
    input  logic imem_rready,

    input  logic dmem_arvalid,
    output logic dmem_arready,
    output logic dmem_rvalid,
    input  logic dmem_rready,

    input  logic dmem_awvalid,
    output logic dmem_awready,
    input  logic dmem_wvalid,
    output logic dmem_wready,
    output logic dmem_bvalid,
    input  logic dmem_bready,

    output logic imem_ren,
    output logic dmem_ren,
    output logic aw_latch,
    output logic addr_held,
    output logic wr_commit
);

    localparam int CNT_W = $clog2(`MEM_READ_DELAY + 1);
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`MEM_READ_DELAY - 1);

    // channel 0 is imem, channel 1 is dmem
    logic [1:0] arvalid_v;
    logic [1:0] rready_v;
    logic [1:0] arready_v;
    logic [1:0] rvalid_v;
    logic [1:0] ren_v;

    assign arvalid_v = {dmem_arvalid, imem_arvalid};
    assign rready_v  = {dmem_rready, imem_rready};

    for (genvar g = 0; g < 2; g++) begin : g_rd
        rd_state_e        state;
        logic [CNT_W-1:0] cnt;

        assign arready_v[g] = (state == rd_idle);
        assign rvalid_v[g]  = (state == rd_resp);
        assign ren_v[g]     = arvalid_v[g] && arready_v[g];

        always_ff @(posedge clk) begin
            if (rst) begin
                state <= rd_idle;
                cnt   <= '0;
            end else begin
                case (state)
                    rd_idle: begin
                        if (ren_v[g]) begin
                            state <= rd_wait;
                            cnt   <= CNT_LOAD;
                        end
                    end
                    rd_wait: begin
                        // last wait cycle moves to response
                        if (cnt == '0) begin
                            state <= rd_resp;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    rd_resp: begin
                        if (rready_v[g]) begin
                            state <= rd_idle;
                        end
                    end
                    default: state <= rd_idle;
                endcase
            end
        end

        a_rvalid_hold: assert property (
            @(posedge clk) disable iff (rst)
            rvalid_v[g] && !rready_v[g] |=> rvalid_v[g]
        );
    end

    assign imem_arready = arready_v[0];
    assign imem_rvalid  = rvalid_v[0];
    assign imem_ren     = ren_v[0];
    assign dmem_arready = arready_v[1];
    assign dmem_rvalid  = rvalid_v[1];
    assign dmem_ren     = ren_v[1];

    wr_state_e wr_state;
    logic      aw_fire;

    assign dmem_awready = (wr_state == wr_idle);
    assign addr_held    = (wr_state == wr_addr_held);
    assign dmem_wready  = addr_held || (dmem_awready && dmem_awvalid);
    assign dmem_bvalid  = (wr_state == wr_resp);
    assign aw_fire      = dmem_awvalid && dmem_awready;
    assign aw_latch     = aw_fire;
    assign wr_commit    = dmem_wvalid && dmem_wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: begin
                    // data may come in the same cycle as the address
                    if (aw_fire && wr_commit) begin
                        wr_state <= wr_resp;
                    end else if (aw_fire) begin
                        wr_state <= wr_addr_held;
                    end
                end
                wr_addr_held: begin
                    if (wr_commit) begin
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (dmem_bready) begin
                        wr_state <= wr_idle;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        dmem_bvalid && !dmem_bready |=> dmem_bvalid
    );

    // held address comes from an earlier accept not yet committed
    a_commit_has_addr: assert property (
        @(posedge clk) disable iff (rst)
        wr_commit && !aw_fire |-> $past((aw_fire || addr_held) && !wr_commit)
    );

endmodule

`default_nettype wire

/* rtl/mem_array.sv */
`default_nettype none

`include "mem_config.svh"

module mem_array
    import mem_bus_pkg::*;
(
    input  logic                    clk,

    input  logic                    imem_ren,
    input  logic [31:0]             imem_addr,
    input  logic                    dmem_ren,
    input  logic [31:0]             dmem_addr,

    input  logic                    wr_commit,
    input  logic [`MEM_INDEX_W-1:0] wr_index,
    input  logic [31:0]             wr_data,
    input  logic [3:0]              wr_mask,
    input  logic                    wr_in_range,

    output logic [31:0]             imem_rdata,
    output mem_resp_e               imem_rresp,
    output logic [31:0]             dmem_rdata,
    output mem_resp_e               dmem_rresp
);

    logic [31:0] mem [`MEM_DEPTH_WORDS];

    // port 0 is imem, port 1 is dmem
    logic [1:0]  ren_v;
    logic [31:0] rd_addr [2];
    logic [31:0] rdata_q [2];
    mem_resp_e   rresp_q [2];

    assign ren_v      = {dmem_ren, imem_ren};
    assign rd_addr[0] = imem_addr;
    assign rd_addr[1] = dmem_addr;

    for (genvar g = 0; g < 2; g++) begin : g_rd
        always_ff @(posedge clk) begin
            if (ren_v[g]) begin
                if (rd_addr[g][31:2] < 30'(`MEM_DEPTH_WORDS)) begin
                    rdata_q[g] <= mem[rd_addr[g][`MEM_INDEX_W+1:2]];
                    rresp_q[g] <= resp_okay;
                end else begin
                    rdata_q[g] <= '0;
                    rresp_q[g] <= resp_slverr;
                end
            end
        end
    end

    assign imem_rdata = rdata_q[0];
    assign imem_rresp = rresp_q[0];
    assign dmem_rdata = rdata_q[1];
    assign dmem_rresp = rresp_q[1];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (wr_commit && wr_in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    a_commit_mask_known: assert property (
        @(posedge clk)
        wr_commit |-> !$isunknown(wr_mask) && !$isunknown(wr_in_range)
    );

endmodule

`default_nettype wire

/* rtl/mem_write_path.sv */
`default_nettype none

`include "mem_config.svh"

module mem_write_path
    import mem_bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [31:0]             dmem_awaddr,
    input  logic                    aw_latch,
    input  logic                    addr_held,
    input  logic [31:0]             dmem_wdata,
    input  logic [3:0]              dmem_wmask,

    output logic [`MEM_INDEX_W-1:0] wr_index,
    output logic [31:0]             wr_data,
    output logic [3:0]              wr_mask,
    output logic                    wr_in_range,
    output mem_resp_e               dmem_bresp
);

    logic [31:0] awaddr_q;
    logic [31:0] addr_use;

    always_ff @(posedge clk) begin
        if (aw_latch) begin
            awaddr_q <= dmem_awaddr;
        end
    end

    // held address wins once the address phase is done
    assign addr_use = addr_held ? awaddr_q : dmem_awaddr;

    assign wr_index    = addr_use[`MEM_INDEX_W+1:2];
    assign wr_in_range = (addr_use[31:2] < 30'(`MEM_DEPTH_WORDS));
    assign wr_data     = dmem_wdata << {addr_use[1:0], 3'b000};
    // upper mask bits fall off the 4-bit result
    assign wr_mask     = dmem_wmask << addr_use[1:0];

    // response only depends on the accepted address, stable through commit
    always_ff @(posedge clk) begin
        if (rst) begin
            dmem_bresp <= resp_okay;
        end else if (aw_latch) begin
            if (dmem_awaddr[31:2] < 30'(`MEM_DEPTH_WORDS)) begin
                dmem_bresp <= resp_okay;
            end else begin
                dmem_bresp <= resp_slverr;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_subsys.sv */
`default_nettype none

`include "mem_config.svh"

module mem_subsys
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // imem read
    input  logic [31:0] imem_araddr,
    input  logic        imem_arvalid,
    output logic        imem_arready,
    output logic [31:0] imem_rdata,
    output mem_resp_e   imem_rresp,
    output logic        imem_rvalid,
    input  logic        imem_rready,

    // dmem read
    input  logic [31:0] dmem_araddr,
    input  logic        dmem_arvalid,
    output logic        dmem_arready,
    output logic [31:0] dmem_rdata,
    output mem_resp_e   dmem_rresp,
    output logic        dmem_rvalid,
    input  logic        dmem_rready,

    // dmem write
    input  logic [31:0] dmem_awaddr,
    input  logic        dmem_awvalid,
    output logic        dmem_awready,
    input  logic [31:0] dmem_wdata,
    input  logic [3:0]  dmem_wmask,
    input  logic        dmem_wvalid,
    output logic        dmem_wready,
    output mem_resp_e   dmem_bresp,
    output logic        dmem_bvalid,
    input  logic        dmem_bready
);

    logic                    imem_ren;
    logic                    dmem_ren;
    logic                    aw_latch;
    logic                    addr_held;
    logic                    wr_commit;
    logic [`MEM_INDEX_W-1:0] wr_index;
    logic [31:0]             wr_data;
    logic [3:0]              wr_mask;
    logic                    wr_in_range;

    mem_ctrl i_mem_ctrl (
        .clk          (clk),
        .rst          (rst),
        .imem_arvalid (imem_arvalid),
        .imem_arready (imem_arready),
        .imem_rvalid  (imem_rvalid),
        .imem_rready  (imem_rready),
        .dmem_arvalid (dmem_arvalid),
        .dmem_arready (dmem_arready),
        .dmem_rvalid  (dmem_rvalid),
        .dmem_rready  (dmem_rready),
        .dmem_awvalid (dmem_awvalid),
        .dmem_awready (dmem_awready),
        .dmem_wvalid  (dmem_wvalid),
        .dmem_wready  (dmem_wready),
        .dmem_bvalid  (dmem_bvalid),
        .dmem_bready  (dmem_bready),
        .imem_ren     (imem_ren),
        .dmem_ren     (dmem_ren),
        .aw_latch     (aw_latch),
        .addr_held    (addr_held),
        .wr_commit    (wr_commit)
    );

    mem_write_path i_mem_write_path (
        .clk         (clk),
        .rst         (rst),
        .dmem_awaddr (dmem_awaddr),
        .aw_latch    (aw_latch),
        .addr_held   (addr_held),
        .dmem_wdata  (dmem_wdata),
        .dmem_wmask  (dmem_wmask),
        .wr_index    (wr_index),
        .wr_data     (wr_data),
        .wr_mask     (wr_mask),
        .wr_in_range (wr_in_range),
        .dmem_bresp  (dmem_bresp)
    );

    mem_array i_mem_array (
        .clk         (clk),
        .imem_ren    (imem_ren),
        .imem_addr   (imem_araddr),
        .dmem_ren    (dmem_ren),
        .dmem_addr   (dmem_araddr),
        .wr_commit   (wr_commit),
        .wr_index    (wr_index),
        .wr_data     (wr_data),
        .wr_mask     (wr_mask),
        .wr_in_range (wr_in_range),
        .imem_rdata  (imem_rdata),
        .imem_rresp  (imem_rresp),
        .dmem_rdata  (dmem_rdata),
        .dmem_rresp  (dmem_rresp)
    );

endmodule

`default_nettype wire

/* tb/tb_mem_subsys.sv */
`default_nettype none

`include "mem_config.svh"

module tb_mem_subsys
    import mem_bus_pkg::*;
;

    localparam int N_BYTE = 64;
    localparam int N_CONC = 48;
    localparam int N_TXN  = `MEM_DEPTH_WORDS + 2 * N_BYTE + 3 * N_CONC + 8;

    logic        clk;
    logic        rst;
    logic [31:0] imem_araddr;
    logic        imem_arvalid;
    logic        imem_arready;
    logic [31:0] imem_rdata;
    mem_resp_e   imem_rresp;
    logic        imem_rvalid;
    logic        imem_rready;
    logic [31:0] dmem_araddr;
    logic        dmem_arvalid;
    logic        dmem_arready;
    logic [31:0] dmem_rdata;
    mem_resp_e   dmem_rresp;
    logic        dmem_rvalid;
    logic        dmem_rready;
    logic [31:0] dmem_awaddr;
    logic        dmem_awvalid;
    logic        dmem_awready;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_wmask;
    logic        dmem_wvalid;
    logic        dmem_wready;
    mem_resp_e   dmem_bresp;
    logic        dmem_bvalid;
    logic        dmem_bready;

    mem_subsys i_mem_subsys (.*);

    // reference state
    logic [31:0]       shadow [`MEM_DEPTH_WORDS];
    logic [1:0][33:0]  rexp;
    logic [1:0][33:0]  held_r;
    logic [1:0]        rpend;
    logic [1:0]        rv_prev;
    logic [1:0]        hold_r;
    int                acc_cyc [2];
    int                cyc;
    mem_resp_e         bexp;
    logic [1:0]        held_bresp;
    logic              bpend;
    logic              hold_b;
    logic [31:0]       aw_addr_q;
    logic [31:0]       wa;
    int                err_cnt = 0;
    int                proto_cnt = 0;
    string             chn [2] = '{"imem", "dmem"};

    logic [1:0]       rvalid_v;
    logic [1:0]       rready_v;
    logic [1:0]       ar_fire;
    logic [1:0][31:0] ar_addr;
    logic [1:0][33:0] rpay;
    logic             aw_fire;

    assign rvalid_v = {dmem_rvalid, imem_rvalid};
    assign rready_v = {dmem_rready, imem_rready};
    assign ar_fire  = {dmem_arvalid && dmem_arready, imem_arvalid && imem_arready};
    assign ar_addr  = {dmem_araddr, imem_araddr};
    assign rpay     = {{dmem_rresp, dmem_rdata}, {imem_rresp, imem_rdata}};
    assign aw_fire  = dmem_awvalid && dmem_awready;

    function automatic bit in_range(input logic [31:0] addr);
        return addr[31:2] < 30'(`MEM_DEPTH_WORDS);
    endfunction

    // word after a write, with data and mask moved up by the low address bits
    function automatic logic [31:0] merge_write(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0]  mask,
                                                input logic [1:0]  lo);
        logic [31:0] sh_data;
        logic [3:0]  sh_mask;
        logic [31:0] res;
        sh_data = data << (8 * lo);
        sh_mask = mask << lo;
        res     = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sh_mask[b]) begin
                res[8*b +: 8] = sh_data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // {resp, data} a read of this address should return
    function automatic logic [33:0] expect_read(input logic [31:0] addr);
        if (in_range(addr)) begin
            return {resp_okay, shadow[addr[`MEM_INDEX_W+1:2]]};
        end
        return {resp_slverr, 32'h0};
    endfunction

    function automatic logic [31:0] rand_addr(input int words);
        return ($urandom_range(words - 1) << 2) | $urandom_range(3);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            err_cnt++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // response back-pressure
    initial begin
        imem_rready = 1'b0;
        dmem_rready = 1'b0;
        dmem_bready = 1'b0;
        forever begin
            @(negedge clk);
            imem_rready = ($urandom_range(3) != 0);
            dmem_rready = ($urandom_range(3) != 0);
            dmem_bready = ($urandom_range(3) != 0);
        end
    end

    initial begin
        repeat (N_TXN * (`MEM_READ_DELAY + 20)) @(posedge clk);
        $display("watchdog expired at %0t, a transfer never completed", $time);
        $display("Simulation FAILED");
        $finish;
    end

    // compare process, sampled at the edge where transfers happen
    always @(posedge clk) begin
        if (rst) begin
            cyc     = 0;
            rpend   = '0;
            rv_prev = '0;
            hold_r  = '0;
            hold_b  = 1'b0;
            bpend   = 1'b0;
        end else begin
            cyc++;
            for (int c = 0; c < 2; c++) begin
                if (hold_r[c]) begin
                    check({chn[c], "_rvalid held"}, 32'd1, 32'(rvalid_v[c]));
                    check({chn[c], "_rdata held"}, held_r[c][31:0], rpay[c][31:0]);
                    check({chn[c], "_rresp held"}, 32'(held_r[c][33:32]),
                          32'(rpay[c][33:32]));
                end
                if (rvalid_v[c] && !rv_prev[c]) begin
                    if (!rpend[c]) begin
                        $display("%s read response at %0t with no read outstanding",
                                 chn[c], $time);
                        proto_cnt++;
                    end else begin
                        check({chn[c], "_rvalid latency"}, `MEM_READ_DELAY,
                              32'(cyc - acc_cyc[c] - 1));
                    end
                end
                if (rvalid_v[c] && rready_v[c] && rpend[c]) begin
                    check({chn[c], "_rdata"}, rexp[c][31:0], rpay[c][31:0]);
                    check({chn[c], "_rresp"}, 32'(rexp[c][33:32]), 32'(rpay[c][33:32]));
                    rpend[c] = 1'b0;
                end
                rv_prev[c] = rvalid_v[c];
                hold_r[c]  = rvalid_v[c] && !rready_v[c];
                held_r[c]  = rpay[c];
                // taken before the commit below, so a same-edge read sees old data
                if (ar_fire[c]) begin
                    rexp[c]    = expect_read(ar_addr[c]);
                    rpend[c]   = 1'b1;
                    acc_cyc[c] = cyc;
                end
            end

            if (hold_b) begin
                check("dmem_bvalid held", 32'd1, 32'(dmem_bvalid));
                check("dmem_bresp held", 32'(held_bresp), 32'(dmem_bresp));
            end
            if (dmem_bvalid && dmem_bready) begin
                if (!bpend) begin
                    $display("write response at %0t with no write outstanding", $time);
                    proto_cnt++;
                end else begin
                    check("dmem_bresp", 32'(bexp), 32'(dmem_bresp));
                end
                bpend = 1'b0;
            end
            hold_b     = dmem_bvalid && !dmem_bready;
            held_bresp = dmem_bresp;

            wa = aw_fire ? dmem_awaddr : aw_addr_q;
            if (aw_fire) begin
                aw_addr_q = dmem_awaddr;
            end
            if (dmem_wvalid && dmem_wready) begin
                if (in_range(wa)) begin
                    shadow[wa[`MEM_INDEX_W+1:2]] = merge_write(shadow[wa[`MEM_INDEX_W+1:2]],
                        dmem_wdata, dmem_wmask, wa[1:0]);
                    bexp = resp_okay;
                end else begin
                    bexp = resp_slverr;
                end
                bpend = 1'b1;
            end
        end
    end

    // order 0 address first, 1 data first, 2 same cycle
    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask, input int order);
        fork
            begin
                if (order == 1) begin
                    repeat (1 + $urandom_range(2)) @(negedge clk);
                end
                dmem_awaddr  = addr;
                dmem_awvalid = 1'b1;
                do @(posedge clk); while (!dmem_awready);
                @(negedge clk);
                dmem_awvalid = 1'b0;
            end
            begin
                if (order == 0) begin
                    repeat (1 + $urandom_range(2)) @(negedge clk);
                end
                dmem_wdata  = data;
                dmem_wmask  = mask;
                dmem_wvalid = 1'b1;
                do @(posedge clk); while (!dmem_wready);
                @(negedge clk);
                dmem_wvalid = 1'b0;
            end
        join
        do @(posedge clk); while (!(dmem_bvalid && dmem_bready));
        @(negedge clk);
    endtask

    task automatic do_read(input int ch, input logic [31:0] addr);
        if (ch == 0) begin
            imem_araddr  = addr;
            imem_arvalid = 1'b1;
            do @(posedge clk); while (!imem_arready);
            @(negedge clk);
            imem_arvalid = 1'b0;
        end else begin
            dmem_araddr  = addr;
            dmem_arvalid = 1'b1;
            do @(posedge clk); while (!dmem_arready);
            @(negedge clk);
            dmem_arvalid = 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (rpend != 2'b00 || bpend) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    initial begin
        logic [31:0] addr;
        void'($urandom(32'hc848_3f2b));
        rst          = 1'b1;
        imem_araddr  = '0;
        imem_arvalid = 1'b0;
        dmem_araddr  = '0;
        dmem_arvalid = 1'b0;
        dmem_awaddr  = '0;
        dmem_awvalid = 1'b0;
        dmem_wdata   = '0;
        dmem_wmask   = '0;
        dmem_wvalid  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check("imem_arready", 32'd1, 32'(imem_arready));
        check("dmem_arready", 32'd1, 32'(dmem_arready));
        check("dmem_awready", 32'd1, 32'(dmem_awready));
        check("imem_rvalid", 32'd0, 32'(imem_rvalid));
        check("dmem_rvalid", 32'd0, 32'(dmem_rvalid));
        check("dmem_bvalid", 32'd0, 32'(dmem_bvalid));
        check("dmem_wready", 32'd0, 32'(dmem_wready));

        // fill every word so later reads are known
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
            do_write(32'(i * 4), $urandom, 4'hf, i % 3);
        end

        do_write(32'h40, 32'hcafe_f00d, 4'hf, 2);
        do_read(1, 32'h40);
        do_read(0, 32'h40);
        wait_idle();

        repeat (N_BYTE) begin
            addr = rand_addr(`MEM_DEPTH_WORDS);
            do_write(addr, $urandom, 4'($urandom), $urandom_range(2));
            do_read(1, {addr[31:2], 2'b00});
        end
        wait_idle();

        // out of range write aliases word 2 if the range check fails
        do_read(0, 32'(`MEM_DEPTH_WORDS * 4 + 12));
        do_write(32'(`MEM_DEPTH_WORDS * 4 + 8), 32'hdead_beef, 4'hf, 0);
        do_read(1, 32'h8);
        wait_idle();

        // small address window so reads and writes collide
        fork
            repeat (N_CONC) begin
                do_write(rand_addr(16), $urandom, 4'($urandom), $urandom_range(2));
            end
            repeat (N_CONC) begin
                repeat ($urandom_range(2)) @(negedge clk);
                do_read(0, rand_addr(16));
            end
            repeat (N_CONC) begin
                repeat ($urandom_range(2)) @(negedge clk);
                do_read(1, rand_addr(16));
            end
        join
        wait_idle();

        $display("errors: %0d value mismatches, %0d protocol failures", err_cnt, proto_cnt);
        if (err_cnt == 0 && proto_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/mem_ctrl_pkg.sv
rtl/mem_ctrl.sv
rtl/mem_array.sv
rtl/mem_write_path.sv
rtl/mem_subsys.sv
tb/tb_mem_subsys.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mem_subsys
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
